/* tb/spi_flash_cases.txt */
# name            op    addr    len  credit_delay
# op is read or id, addr in hex, len 0 means 256, delay in clock cycles
rd_single         read  000000  1    0
rd_four           read  001234  4    0
rd_seventeen      read  0ABCF0  17   2
rd_wrap           read  FFFFFE  17   0
rd_full           read  12FF80  0    1
id_basic          id    000000  0    0
id_len_ignored    id    FFFFFF  200  3
rd_slow_credit    read  00FF00  12   150
rd_b2b_a          read  000100  3    0
id_b2b            id    000000  1    0
rd_b2b_b          read  7FFFFF  2    0
rd_b2b_c          read  000010  5    5

/* files.f */
src/spi_flash_pkg.sv
src/spi_byte_engine.sv
src/flash_read_seq.sv
src/spi_flash_sys.sv
tb/spi_flash_model.sv
tb/spi_flash_assertions.sv
tb/tb_spi_flash_sys.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_spi_flash_sys
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_spi_flash_sys.sv */
// Testbench for the SPI flash reader, runs the requests of the case file against a flash model
module tb_spi_flash_sys;
  import spi_flash_pkg::*;

  logic        wb_clk_i = 1'b0;
  logic        reset_i = 1'b1;
  logic        req_valid_i = 1'b0;
  flash_req_t  req_i = '0;
  logic        req_ready_o;
  logic        data_valid_o;
  flash_data_t data_o;
  logic        credit_i = 1'b0;
  logic        sclk_o;
  logic        mosi_o;
  logic        miso_i;
  logic        cs_n_o;

  // Cases as read from the file
  logic [8*24-1:0] case_name[$];
  bit              case_is_id[$];
  logic [23:0]     case_addr[$];
  int              case_len[$];
  int              case_delay[$];

  // Bytes of the running request and credit due cycles
  logic [7:0]      rx_data[$];
  bit              rx_last[$];
  int              credit_due[$];
  logic [8*24-1:0] cur_name = '0;
  int              cur_delay = 0;
  int              neg_cycle = 0;
  bit              in_flight = 1'b0;
  bit              got_last = 1'b0;
  int              errors = 0;
  int              tests_failed = 0;
  int              budget_cycles = 0;
  int              seed = 32'h2ea06f9f;

  spi_flash_sys u_spi_flash_sys (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .credit_i     (credit_i),
    .sclk_o       (sclk_o),
    .mosi_o       (mosi_o),
    .miso_i       (miso_i),
    .cs_n_o       (cs_n_o)
  );

  spi_flash_model u_spi_flash_model (
    .sclk_i (sclk_o),
    .cs_n_i (cs_n_o),
    .mosi_i (mosi_o),
    .miso_o (miso_i)
  );

  initial begin
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // ------------------------------------------------------------------
  // Reference rules
  // ------------------------------------------------------------------
  // ID is EFh 40h 18h, memory byte is low ^ middle address byte ^ 5Ah
  function automatic logic [7:0] expected_byte(input bit is_id, input logic [23:0] base,
                                               input int idx);
    logic [23:0] a;
    logic [7:0]  b;
    a = base + 24'(idx);
    b = a[7:0] ^ a[15:8] ^ 8'h5A;
    if (is_id) begin
      b = (idx == 0) ? 8'hEF : ((idx == 1) ? 8'h40 : 8'h18);
    end
    return b;
  endfunction

  // Length 0 means 256, ID always 3 bytes
  function automatic int byte_count(input int idx);
    if (case_is_id[idx]) begin
      return ID_BYTES;
    end
    return (case_len[idx] == 0) ? 256 : case_len[idx];
  endfunction

  // ------------------------------------------------------------------
  // One clock, sampled and driven on the falling edge
  // ------------------------------------------------------------------
  task automatic tick();
    @(negedge wb_clk_i);
    neg_cycle = neg_cycle + 1;
    if (data_valid_o) begin
      assert (in_flight) else begin
        $display("Output byte %02h arrived with no request in flight", data_o.data);
        errors++;
      end
      rx_data.push_back(data_o.data);
      rx_last.push_back(data_o.last);
      credit_due.push_back(neg_cycle + cur_delay);
      got_last = got_last | data_o.last;
    end
    if (in_flight && !got_last) begin
      assert (!req_ready_o) else begin
        $display("Request port ready before the last byte of %0s", cur_name);
        errors++;
      end
    end
    assert (credit_due.size() <= DATA_CREDITS) else begin
      $display("More than %0d bytes outstanding without a credit", DATA_CREDITS);
      errors++;
    end
    // Return at most one credit per cycle once its delay ran out
    if (credit_due.size() > 0 && credit_due[0] <= neg_cycle) begin
      void'(credit_due.pop_front());
      credit_i = 1'b1;
    end else begin
      credit_i = 1'b0;
    end
  endtask

  task automatic load_cases(output bit ok);
    int              fd;
    int              code;
    string           line;
    logic [8*24-1:0] name;
    logic [8*8-1:0]  op_word;
    logic [23:0]     addr;
    int              len;
    int              delay;
    ok = 1'b0;
    fd = $fopen("tb/spi_flash_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Skip comment and blank lines
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%s %s %h %d %d", name, op_word, addr, len, delay);
          if (code == 5) begin
            case_name.push_back(name);
            case_is_id.push_back(op_word == "id");
            case_addr.push_back(addr);
            case_len.push_back(len);
            case_delay.push_back(delay);
          end
        end
      end
      $fclose(fd);
      ok = (case_name.size() > 0);
    end
  endtask

  // ------------------------------------------------------------------
  // One request, random idle gap first
  // ------------------------------------------------------------------
  task automatic run_case(input int idx);
    flash_req_t req;
    int         n;
    int         gap;
    int         err_start;
    logic [7:0] exp_b;
    err_start = errors;
    gap = $unsigned($random(seed)) % 8;
    repeat (gap) tick();
    assert (cs_n_o && req_ready_o) else begin
      $display("Chip select low or request port busy before %0s", case_name[idx]);
      errors++;
    end
    cur_name  = case_name[idx];
    cur_delay = case_delay[idx];
    n         = byte_count(idx);
    req.op    = case_is_id[idx] ? OP_READ_ID : OP_READ;
    req.addr  = case_addr[idx];
    req.len   = 8'(case_len[idx]);
    rx_data.delete();
    rx_last.delete();
    got_last    = 1'b0;
    req_i       = req;
    req_valid_i = 1'b1;
    in_flight   = 1'b1;
    tick();
    req_valid_i = 1'b0;
    while (!got_last) tick();
    in_flight = 1'b0;
    // Chip-select-high transfer, then back to idle
    while (!req_ready_o) tick();
    assert (rx_data.size() == n) else begin
      $display("MISMATCH %0s byte count: expected %0d actual %0d", cur_name, n,
               rx_data.size());
      errors++;
    end
    foreach (rx_data[i]) begin
      exp_b = expected_byte(case_is_id[idx], case_addr[idx], i);
      assert (rx_data[i] == exp_b) else begin
        $display("MISMATCH %0s byte %0d: expected %02h actual %02h", cur_name, i, exp_b,
                 rx_data[i]);
        errors++;
      end
      assert (rx_last[i] == (i == n - 1)) else begin
        $display("MISMATCH %0s last flag of byte %0d: expected %0d actual %0d", cur_name, i,
                 (i == n - 1), rx_last[i]);
        errors++;
      end
    end
    if (errors == err_start) begin
      $display("PASS %0s: %0d bytes", cur_name, n);
    end else begin
      $display("FAIL %0s: %0d errors", cur_name, errors - err_start);
      tests_failed++;
    end
  endtask

  // Ends the run once the case budget is spent
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge wb_clk_i);
    $display("Timeout after %0d cycles, a request never completed", budget_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    bit loaded;
    int budget;
    budget = 0;
    load_cases(loaded);
    if (!loaded) begin
      $display("No cases could be read from tb/spi_flash_cases.txt");
      $display("TB FAILED");
      $finish;
    end else begin
      foreach (case_name[i]) begin
        budget = budget + (byte_count(i) + 5) * 40 * (1 + case_delay[i]);
      end
      budget_cycles = budget + 1000 + 8 * case_name.size();
      repeat (3) tick();
      reset_i = 1'b0;
      tick();
      // Idle levels after reset
      assert (cs_n_o && sclk_o && mosi_o && req_ready_o && !data_valid_o) else begin
        $display("Pads or ports not idle after reset");
        errors++;
        tests_failed++;
      end
      foreach (case_name[i]) run_case(i);
      while (credit_due.size() > 0) tick();
      // Failures seen by the bound checker
      errors = errors + u_spi_flash_sys.u_spi_flash_sys_assertions.fail_cnt;
      $display("Tests: %0d run, %0d failed, %0d errors", case_name.size(), tests_failed,
               errors);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

/* tb/spi_flash_assertions.sv */
// Concurrent checks on the SPI pins and the credit port, bound into the reader top level
module spi_flash_sys_assertions (
  input logic wb_clk_i,
  input logic reset_i,
  input logic cs_n_i,
  input logic sclk_i,
  input logic mosi_i,
  input logic ack_i,
  input logic data_valid_i,
  input logic credit_i
);
  import spi_flash_pkg::*;

  // Consumer side credit count
  int credit_cnt;
  // Number of failed checks
  int fail_cnt = 0;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      credit_cnt <= DATA_CREDITS;
    end else begin
      credit_cnt <= credit_cnt - int'(data_valid_i) + int'(credit_i);
    end
  end

  // ------------------------------------------------------------------
  // Pin rules
  // ------------------------------------------------------------------
  sclk_idle_cs: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    cs_n_i |-> sclk_i)
    else begin
      $error("SCLK low while chip select is high");
      fail_cnt++;
    end

  // Mode 3, MOSI only moves with the falling edge
  mosi_hold: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    sclk_i |-> $stable(mosi_i))
    else begin
      $error("MOSI changed while SCLK was high");
      fail_cnt++;
    end

  ack_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    ack_i |=> !ack_i)
    else begin
      $error("Engine ack high on two cycles in a row");
      fail_cnt++;
    end

  // ------------------------------------------------------------------
  // Credit port
  // ------------------------------------------------------------------
  byte_needs_credit: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    data_valid_i |-> (credit_cnt > 0))
    else begin
      $error("Output byte issued with no credit left");
      fail_cnt++;
    end

endmodule

bind spi_flash_sys spi_flash_sys_assertions u_spi_flash_sys_assertions (
  .wb_clk_i     (wb_clk_i),
  .reset_i      (reset_i),
  .cs_n_i       (cs_n_o),
  .sclk_i       (sclk_o),
  .mosi_i       (mosi_o),
  .ack_i        (wb_rsp.ack),
  .data_valid_i (data_valid_o),
  .credit_i     (credit_i)
);

/* tb/spi_flash_model.sv */
// Behavioral SPI flash for the testbench, answers READ (03h) and JEDEC ID (9Fh) in SPI mode 3
module spi_flash_model (
  input  logic sclk_i,
  input  logic cs_n_i,
  input  logic mosi_i,
  output logic miso_o
);
  import spi_flash_pkg::*;

  // Command bytes sampled on rising SCLK
  logic [7:0]  rx_sr = 8'h00;
  logic [7:0]  cmd = 8'h00;
  logic [23:0] addr = 24'h000000;
  logic [7:0]  tx_byte;
  int          bit_cnt = 0;
  int          byte_cnt = 0;

  initial miso_o = 1'b1;

  // Memory pattern, low ^ middle address byte ^ 5Ah
  function automatic logic [7:0] pattern_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5A;
  endfunction

  // Byte driven during frame byte idx, FFh when nothing to say
  function automatic logic [7:0] reply_byte(input int idx);
    logic [7:0] b;
    b = 8'hFF;
    if (cmd == CMD_READ_ID && idx == 1) begin
      b = 8'hEF;
    end else if (cmd == CMD_READ_ID && idx == 2) begin
      b = 8'h40;
    end else if (cmd == CMD_READ_ID && idx == 3) begin
      b = 8'h18;
    end else if (cmd == CMD_READ && idx > ADDR_BYTES) begin
      // Address wraps at 24 bits
      b = pattern_byte(addr + 24'(idx - ADDR_BYTES - 1));
    end
    return b;
  endfunction

  // ------------------------------------------------------------------
  // Frame tracking
  // ------------------------------------------------------------------
  always @(negedge cs_n_i) begin
    bit_cnt  = 0;
    byte_cnt = 0;
    cmd      = 8'h00;
  end

  // Output released high between frames
  always @(posedge cs_n_i) begin
    miso_o = 1'b1;
  end

  always @(posedge sclk_i) begin
    if (cs_n_i === 1'b0) begin
      rx_sr   = {rx_sr[6:0], mosi_i};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8) begin
        if (byte_cnt == 0) begin
          cmd = rx_sr;
        end else if (cmd == CMD_READ && byte_cnt <= ADDR_BYTES) begin
          addr = {addr[15:0], rx_sr};
        end
        bit_cnt  = 0;
        byte_cnt = byte_cnt + 1;
      end
    end
  end

  // MSB first, new bit on each falling edge
  always @(negedge sclk_i) begin
    if (cs_n_i === 1'b0) begin
      tx_byte = reply_byte(byte_cnt);
      miso_o  = tx_byte[7 - bit_cnt];
    end
  end

endmodule

/* src/spi_flash_sys.sv */
// SPI flash reader top, sequencer driving the byte engine onto the flash pads
module spi_flash_sys (
  input  logic                       wb_clk_i,
  input  logic                       reset_i,
  // Host request port
  input  logic                       req_valid_i,
  input  spi_flash_pkg::flash_req_t  req_i,
  output logic                       req_ready_o,
  // Data output with credit return
  output logic                       data_valid_o,
  output spi_flash_pkg::flash_data_t data_o,
  input  logic                       credit_i,
  // SPI pads
  output logic                       sclk_o,
  output logic                       mosi_o,
  input  logic                       miso_i,
  output logic                       cs_n_o
);
  import spi_flash_pkg::*;

  // ------------------------------------------------------------------
  // Internal Wishbone link
  // ------------------------------------------------------------------
  spi_wb_req_t wb_req;
  spi_wb_rsp_t wb_rsp;

  // Wishbone master, one transfer in flight
  flash_read_seq u_flash_read_seq (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .wb_req_o     (wb_req),
    .wb_rsp_i     (wb_rsp),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .credit_i     (credit_i)
  );

  // Byte-serial SPI slave on the same clock
  spi_byte_engine u_spi_byte_engine (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .sclk_o   (sclk_o),
    .mosi_o   (mosi_o),
    .miso_i   (miso_i),
    .cs_n_o   (cs_n_o)
  );

endmodule

/* src/flash_read_seq.sv */
// Read sequencer, turns host read or JEDEC ID requests into byte-engine transfers under output credits
module flash_read_seq (
  input  logic                       wb_clk_i,
  input  logic                       reset_i,
  input  logic                       req_valid_i,
  input  spi_flash_pkg::flash_req_t  req_i,
  output logic                       req_ready_o,
  output spi_flash_pkg::spi_wb_req_t wb_req_o,
  input  spi_flash_pkg::spi_wb_rsp_t wb_rsp_i,
  output logic                       data_valid_o,
  output spi_flash_pkg::flash_data_t data_o,
  input  logic                       credit_i
);
  import spi_flash_pkg::*;

  seq_state_e state;
  flash_op_e  op_q;
  // Address bytes leave from the top
  logic [23:0] addr_q;
  logic [1:0]  addr_cnt;
  // Bytes still to read, up to 256
  logic [8:0]  remain;
  logic [CREDIT_W-1:0] credits;
  logic        stb_q;

  logic       req_take;
  logic       xfer_ack;
  logic       xfer_go;
  logic       data_take;
  logic [7:0] cmd_byte;

  // ------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------
  assign req_ready_o = (state == S_IDLE);
  assign req_take    = req_valid_i & req_ready_o;
  assign xfer_ack    = wb_rsp_i.ack & stb_q;
  assign data_take   = xfer_ack & (state == S_DATA);

  // Strobe rises one cycle after the previous ack
  // Data bytes wait for a free credit
  assign xfer_go = !stb_q && (state != S_IDLE) &&
                   ((state != S_DATA) || (credits != '0));

  assign cmd_byte = (op_q == OP_READ) ? CMD_READ : CMD_READ_ID;

  // ------------------------------------------------------------------
  // Engine request, held stable by state until ack
  // ------------------------------------------------------------------
  always_comb begin
    wb_req_o.cyc = stb_q;
    wb_req_o.stb = stb_q;
    wb_req_o.we  = 1'b1;
    case (state)
      S_CS_LOW: begin
        wb_req_o.sel = 2'b10;
        wb_req_o.dat = 9'h000;
      end
      S_CMD: begin
        wb_req_o.sel = 2'b01;
        wb_req_o.dat = {1'b0, cmd_byte};
      end
      S_ADDR: begin
        wb_req_o.sel = 2'b01;
        wb_req_o.dat = {1'b0, addr_q[23:16]};
      end
      S_DATA: begin
        // Dummy ones while the flash talks
        wb_req_o.sel = 2'b01;
        wb_req_o.dat = 9'h0FF;
      end
      S_CS_HIGH: begin
        wb_req_o.sel = 2'b10;
        wb_req_o.dat = 9'h100;
      end
      default: begin
        wb_req_o.sel = 2'b00;
        wb_req_o.dat = 9'h000;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // Sequencer FSM
  // ------------------------------------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state <= S_IDLE;
      stb_q <= 1'b0;
    end else begin
      if (xfer_ack) begin
        stb_q <= 1'b0;
      end else if (xfer_go) begin
        stb_q <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (req_take) begin
            state <= S_CS_LOW;
          end
        end
        S_CS_LOW: begin
          if (xfer_ack) begin
            state <= S_CMD;
          end
        end
        S_CMD: begin
          // ID read skips the address
          if (xfer_ack) begin
            state <= (op_q == OP_READ) ? S_ADDR : S_DATA;
          end
        end
        S_ADDR: begin
          if (xfer_ack && addr_cnt == 2'd0) begin
            state <= S_DATA;
          end
        end
        S_DATA: begin
          if (xfer_ack && remain == 9'd1) begin
            state <= S_CS_HIGH;
          end
        end
        S_CS_HIGH: begin
          if (xfer_ack) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Request fields and byte counters
  always_ff @(posedge wb_clk_i) begin
    if (req_take) begin
      op_q     <= req_i.op;
      addr_q   <= req_i.addr;
      addr_cnt <= 2'(ADDR_BYTES - 1);
      if (req_i.op == OP_READ_ID) begin
        remain <= 9'(ID_BYTES);
      end else begin
        remain <= (req_i.len == 8'd0) ? 9'd256 : {1'b0, req_i.len};
      end
    end else if (xfer_ack && state == S_ADDR) begin
      addr_q   <= {addr_q[15:0], 8'h00};
      addr_cnt <= addr_cnt - 2'd1;
    end else if (data_take) begin
      remain <= remain - 9'd1;
    end
  end

  // ------------------------------------------------------------------
  // Credits and data output
  // ------------------------------------------------------------------
  // Credit taken at capture, so the next strobe sees it gone
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      credits <= CREDIT_W'(DATA_CREDITS);
    end else begin
      case ({data_take, credit_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      data_valid_o <= 1'b0;
    end else begin
      data_valid_o <= data_take;
    end
  end

  // Captured byte one cycle after its ack
  always_ff @(posedge wb_clk_i) begin
    if (data_take) begin
      data_o.data <= wb_rsp_i.dat;
      data_o.last <= (remain == 9'd1);
    end
  end

endmodule

/* src/spi_byte_engine.sv */
// Wishbone slave SPI byte engine, shifts one byte per strobe and sets chip select on sel bit 1
module spi_byte_engine (
  input  logic                       wb_clk_i,
  input  logic                       reset_i,
  input  spi_flash_pkg::spi_wb_req_t wb_req_i,
  output spi_flash_pkg::spi_wb_rsp_t wb_rsp_o,
  output logic                       sclk_o,
  output logic                       mosi_o,
  input  logic                       miso_i,
  output logic                       cs_n_o
);

  // Free-running divider, SCLK at a quarter of wb_clk_i
  logic [1:0] clk_div;
  // Transmit shift register, MSB goes out next
  logic [7:0] tx_sft;
  // Receive byte, MISO enters at bit 0
  logic [7:0] rx_byte;
  // One-hot bit progress, walks from bit 7 to bit 0
  logic [7:0] bit_prog;
  logic       busy;
  logic       ack;

  logic wb_op;
  logic shift_start;
  logic cs_wr;
  logic div_fall;
  logic div_rise;

  // ------------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------------
  // Ack cycle masked so a held strobe does not start twice
  assign wb_op       = wb_req_i.cyc & wb_req_i.stb & wb_req_i.we & !ack;
  assign shift_start = wb_op & wb_req_i.sel[0] & !busy;
  assign cs_wr       = wb_op & wb_req_i.sel[1] & !busy;

  // Divider phases for the SCLK edges
  assign div_fall = (clk_div == 2'b10);
  assign div_rise = (clk_div == 2'b00);

  assign wb_rsp_o.ack = ack;
  assign wb_rsp_o.dat = rx_byte;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      clk_div <= 2'b00;
    end else begin
      clk_div <= clk_div - 2'd1;
    end
  end

  // ------------------------------------------------------------------
  // Shift control and pads
  // ------------------------------------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      busy     <= 1'b0;
      bit_prog <= 8'h00;
      sclk_o   <= 1'b1;
      mosi_o   <= 1'b1;
    end else if (div_fall) begin
      if (shift_start) begin
        // First falling edge, MSB out at once
        busy     <= 1'b1;
        bit_prog <= 8'h80;
        sclk_o   <= 1'b0;
        mosi_o   <= wb_req_i.dat[7];
      end else if (busy) begin
        bit_prog <= bit_prog >> 1;
        sclk_o   <= 1'b0;
        mosi_o   <= tx_sft[7];
      end
    end else if (div_rise && busy) begin
      // Mode 3 rising edge, SCLK parks high after bit 0
      sclk_o <= 1'b1;
      if (bit_prog[0]) begin
        busy     <= 1'b0;
        bit_prog <= 8'h00;
      end
    end
  end

  // Remaining bits, filled with ones behind
  always_ff @(posedge wb_clk_i) begin
    if (div_fall) begin
      if (shift_start) begin
        tx_sft <= {wb_req_i.dat[6:0], 1'b1};
      end else if (busy) begin
        tx_sft <= {tx_sft[6:0], 1'b1};
      end
    end
  end

  // MISO sampled on each rising edge
  always_ff @(posedge wb_clk_i) begin
    if (div_rise && busy) begin
      rx_byte <= {rx_byte[6:0], miso_i};
    end
  end

  // Single-cycle ack, shift done or plain chip-select write
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack <= 1'b0;
    end else begin
      ack <= (div_rise & busy & bit_prog[0]) | (cs_wr & !wb_req_i.sel[0]);
    end
  end

  // Chip select, active low
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      cs_n_o <= 1'b1;
    end else if (cs_wr) begin
      cs_n_o <= wb_req_i.dat[8];
    end
  end

endmodule

/* src/spi_flash_pkg.sv */
// Shared types and constants for the SPI flash reader, imported by every design module
package spi_flash_pkg;

  // ------------------------------------------------------------------
  // Flash command set and sizes
  // ------------------------------------------------------------------
  localparam logic [7:0] CMD_READ    = 8'h03;
  localparam logic [7:0] CMD_READ_ID = 8'h9F;

  // JEDEC ID is always manufacturer, type, capacity
  localparam int ID_BYTES   = 3;
  localparam int ADDR_BYTES = 3;

  // Bytes the consumer can hold after reset
  localparam int DATA_CREDITS = 4;
  localparam int CREDIT_W     = $clog2(DATA_CREDITS + 1);

  // ------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------
  typedef enum logic {
    OP_READ    = 1'b0,
    OP_READ_ID = 1'b1
  } flash_op_e;

  typedef enum logic [2:0] {
    S_IDLE    = 3'd0,
    S_CS_LOW  = 3'd1,
    S_CMD     = 3'd2,
    S_ADDR    = 3'd3,
    S_DATA    = 3'd4,
    S_CS_HIGH = 3'd5
  } seq_state_e;

  // ------------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------------
  // Host request, len of 0 means 256 bytes
  typedef struct packed {
    flash_op_e   op;
    logic [23:0] addr;
    logic [7:0]  len;
  } flash_req_t;

  // Master side of the byte engine bus
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] sel;
    logic [8:0] dat;
  } spi_wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } spi_wb_rsp_t;

  // Output byte, last marks end of request
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } flash_data_t;

endpackage
